// File: rtl/bp_defs.svh
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// BTB and LHT are both indexed by the pc bits just above the word offset.
`define BTB_IDX_BITS 8
`define LHT_IDX_BITS 8

// Local history length. The history itself indexes the PHT.
`define HIST_BITS 8

`endif

// File: rtl/bp_types.sv
`include "bp_defs.svh"

package bp_types;

    // Two-bit saturating counter. Values 2 and 3 predict taken.
    typedef logic [1:0] counter_t;

    // Local branch history, newest outcome in bit 0.
    typedef logic [`HIST_BITS-1:0] history_t;

    // One line of the branch target buffer.
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } btb_entry_t;

endpackage : bp_types

// File: rtl/rv32i_types.sv
package rv32i_types;

    // Base opcodes seen by the branch unit. Everything else folds into op_b_other.
    typedef enum logic [6:0] {
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_other = 7'b0010011
    } opcode_t;

    typedef enum logic [2:0] {
        branch_f3_beq  = 3'b000,
        branch_f3_bne  = 3'b001,
        branch_f3_blt  = 3'b100,
        branch_f3_bge  = 3'b101,
        branch_f3_bltu = 3'b110,
        branch_f3_bgeu = 3'b111
    } branch_funct3_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic        imm_12;
        logic [5:0]  imm_10_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [3:0]  imm_4_1;
        logic        imm_11;
        logic [6:0]  opcode;
    } b_fmt_t;

    typedef struct packed {
        logic        imm_20;
        logic [9:0]  imm_10_1;
        logic        imm_11;
        logic [7:0]  imm_19_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } j_fmt_t;

    // The same instruction word, seen through each immediate layout.
    typedef union packed {
        i_fmt_t i_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        opcode_t             opcode;
        logic [2:0]          funct3;
        logic [31:0]         pc;
        logic [31:0]         i_imm;
        logic [31:0]         b_imm;
        logic [31:0]         j_imm;
        logic                lht_valid;
        bp_types::history_t  lht_true;
        logic                pht_valid;
        bp_types::counter_t  pht;
        logic                bp;
        logic [31:0]         bp_addr;
    } decode_info_t;

endpackage : rv32i_types

// File: rtl/bp_ifs.sv
`timescale 1ns/1ps
`include "bp_defs.svh"

// Lookup results from the tables to the combiner.
interface pred_if;
    import bp_types::*;

    logic        btb_hit;
    logic [31:0] btb_target;
    logic        lht_valid;
    history_t    lht_true;
    logic        pht_valid;
    counter_t    pht;

    modport table_side (
        output btb_hit, btb_target, lht_valid, lht_true, pht_valid, pht
    );

    modport combine_side (
        input btb_hit, btb_target, lht_valid, lht_true, pht_valid, pht
    );
endinterface : pred_if

// Table writes from the resolver. Both enables are active low.
interface bp_update_if;
    import bp_types::*;

    logic                     btb_web;
    logic [`BTB_IDX_BITS-1:0] btb_addr;
    logic [31:0]              btb_din;
    logic                     ht_web;
    logic [`LHT_IDX_BITS-1:0] lht_addr;
    history_t                 lht_in;
    logic [`HIST_BITS-1:0]    pht_addr;
    counter_t                 pht_in;

    modport resolver (
        output btb_web, btb_addr, btb_din, ht_web, lht_addr, lht_in, pht_addr, pht_in
    );

    modport tables (
        input btb_web, btb_addr, btb_din, ht_web, lht_addr, lht_in, pht_addr, pht_in
    );
endinterface : bp_update_if

// File: rtl/branch_decoder.sv
`timescale 1ns/1ps

module branch_decoder (
    input  rv32i_types::instr_u        instr,
    input  logic [31:0]                pc,
    input  logic                       bp,
    input  logic [31:0]                bp_addr,
    input  logic                       lht_valid,
    input  bp_types::history_t         lht_true,
    input  logic                       pht_valid,
    input  bp_types::counter_t         pht,
    output rv32i_types::decode_info_t  decode_info
);
    import rv32i_types::*;

    opcode_t opcode;

    always_comb begin
        case (instr.i_fmt.opcode)
            op_b_jal  : opcode = op_b_jal;
            op_b_jalr : opcode = op_b_jalr;
            op_b_br   : opcode = op_b_br;
            default   : opcode = op_b_other;
        endcase
    end

    always_comb begin
        decode_info.opcode = opcode;
        decode_info.funct3 = instr.i_fmt.funct3;
        decode_info.pc     = pc;

        decode_info.i_imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
        decode_info.b_imm = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12,
                             instr.b_fmt.imm_11, instr.b_fmt.imm_10_5,
                             instr.b_fmt.imm_4_1, 1'b0};
        // J immediate is scrambled the most; bit 0 is always zero.
        decode_info.j_imm = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20,
                             instr.j_fmt.imm_19_12, instr.j_fmt.imm_11,
                             instr.j_fmt.imm_10_1, 1'b0};

        decode_info.lht_valid = lht_valid;
        decode_info.lht_true  = lht_true;
        decode_info.pht_valid = pht_valid;
        decode_info.pht       = pht;
        decode_info.bp        = bp;
        decode_info.bp_addr   = bp_addr;
    end

endmodule : branch_decoder

// File: rtl/btb.sv
`timescale 1ns/1ps
`include "bp_defs.svh"

module btb (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] pc,
    pred_if.table_side  lookup,
    bp_update_if.tables upd
);
    import bp_types::*;

    localparam int BTB_ENTRIES = 1 << `BTB_IDX_BITS;

    logic [BTB_ENTRIES-1:0]   valid_q;
    logic [31:0]              target_q [BTB_ENTRIES];
    logic [`BTB_IDX_BITS-1:0] rd_idx;
    btb_entry_t               rd_entry;

    assign rd_idx = pc[`BTB_IDX_BITS+1:2];   // Word-aligned pc.

    assign rd_entry.valid  = valid_q[rd_idx];
    assign rd_entry.target = target_q[rd_idx];

    assign lookup.btb_hit    = rd_entry.valid;
    assign lookup.btb_target = rd_entry.target;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (!upd.btb_web) begin
            valid_q[upd.btb_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!upd.btb_web) begin
            target_q[upd.btb_addr] <= upd.btb_din;
        end
    end

endmodule : btb

// File: rtl/history_tables.sv
`timescale 1ns/1ps
`include "bp_defs.svh"

module history_tables (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] pc,
    pred_if.table_side  lookup,
    bp_update_if.tables upd
);
    import bp_types::*;

    localparam int LHT_ENTRIES = 1 << `LHT_IDX_BITS;
    localparam int PHT_ENTRIES = 1 << `HIST_BITS;

    logic [LHT_ENTRIES-1:0]   lht_valid_q;
    history_t                 lht_q [LHT_ENTRIES];
    logic [PHT_ENTRIES-1:0]   pht_valid_q;
    counter_t                 pht_q [PHT_ENTRIES];

    logic [`LHT_IDX_BITS-1:0] lht_idx;
    logic                     lht_hit;
    history_t                 hist;
    logic [`HIST_BITS-1:0]    pht_idx;

    assign lht_idx = pc[`LHT_IDX_BITS+1:2];
    assign lht_hit = lht_valid_q[lht_idx];
    assign hist    = lht_q[lht_idx];

    // Without a history yet, every branch shares PHT entry 0.
    assign pht_idx = lht_hit ? hist : '0;

    assign lookup.lht_valid = lht_hit;
    assign lookup.lht_true  = hist;
    assign lookup.pht_valid = pht_valid_q[pht_idx];
    assign lookup.pht       = pht_q[pht_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            lht_valid_q <= '0;
            pht_valid_q <= '0;
        end else if (!upd.ht_web) begin
            lht_valid_q[upd.lht_addr] <= 1'b1;
            pht_valid_q[upd.pht_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!upd.ht_web) begin
            lht_q[upd.lht_addr] <= upd.lht_in;
            pht_q[upd.pht_addr] <= upd.pht_in;
        end
    end

endmodule : history_tables

// File: rtl/branch_predict.sv
`timescale 1ns/1ps

module branch_predict (
    pred_if.combine_side        lookup,
    output logic                bp,
    output logic [31:0]         bp_addr,
    output logic                lht_valid,
    output bp_types::history_t  lht_true,
    output logic                pht_valid,
    output bp_types::counter_t  pht
);

    logic dir_taken;

    // The counter decides once trained, else the last outcome seen at this pc.
    always_comb begin
        if (lookup.pht_valid) begin
            dir_taken = lookup.pht[1];
        end else begin
            dir_taken = lookup.lht_valid & lookup.lht_true[0];
        end
    end

    // Without a target there is nothing to predict, so a BTB miss is not taken.
    assign bp      = lookup.btb_hit & dir_taken;
    assign bp_addr = lookup.btb_target;

    assign lht_valid = lookup.lht_valid;
    assign lht_true  = lookup.lht_true;
    assign pht_valid = lookup.pht_valid;
    assign pht       = lookup.pht;

endmodule : branch_predict

// File: rtl/fu_br.sv
`timescale 1ns/1ps
`include "bp_defs.svh"

module fu_br (
    input  logic [31:0]               rs1_v,
    input  logic [31:0]               rs2_v,
    input  rv32i_types::decode_info_t decode_info,
    input  logic                      start,
    output logic [31:0]               rd_v,
    output logic                      valid,
    output logic                      busy,
    output logic                      pc_select,
    output logic [31:0]               pc_branch,
    bp_update_if.resolver             upd
);
    import rv32i_types::*;
    import bp_types::*;

    logic        br_en;
    logic        taken;
    logic [31:0] target;
    logic [31:0] link;
    logic        pred_hit;
    history_t    hist_next;
    counter_t    pht_next;

    assign link  = decode_info.pc + 32'd4;
    assign valid = start;
    assign busy  = start;

    always_comb begin
        case (decode_info.funct3)
            branch_f3_beq  : br_en = (rs1_v == rs2_v);
            branch_f3_bne  : br_en = (rs1_v != rs2_v);
            branch_f3_blt  : br_en = ($signed(rs1_v) <  $signed(rs2_v));
            branch_f3_bge  : br_en = ($signed(rs1_v) >= $signed(rs2_v));
            branch_f3_bltu : br_en = (rs1_v <  rs2_v);
            branch_f3_bgeu : br_en = (rs1_v >= rs2_v);
            default        : br_en = 1'b0;   // Reserved funct3 never branches.
        endcase
    end

    // Actual outcome. Target stays zero when nothing is taken.
    always_comb begin
        rd_v   = '0;
        taken  = 1'b0;
        target = '0;
        if (start) begin
            case (decode_info.opcode)
                op_b_jal : begin
                    rd_v   = link;
                    taken  = 1'b1;
                    target = decode_info.pc + decode_info.j_imm;
                end
                op_b_jalr : begin
                    rd_v   = link;
                    taken  = 1'b1;
                    target = (rs1_v + decode_info.i_imm) & ~32'd1;
                end
                op_b_br : begin
                    if (br_en) begin
                        taken  = 1'b1;
                        target = decode_info.pc + decode_info.b_imm;
                    end
                end
                default : begin
                    taken = 1'b0;
                end
            endcase
        end
    end

    assign pred_hit = decode_info.bp && (decode_info.bp_addr == target);

    always_comb begin
        pc_select = 1'b0;
        pc_branch = '0;
        if (start) begin
            if (decode_info.bp && !taken) begin
                pc_select = 1'b1;   // Predicted taken, fall through instead.
                pc_branch = link;
            end else if (taken && !pred_hit) begin
                pc_select = 1'b1;
                pc_branch = target;
            end
        end
    end

    // New history and counter for the tables.
    always_comb begin
        if (!decode_info.lht_valid) begin
            hist_next = {{(`HIST_BITS-1){1'b0}}, taken};
            pht_next  = taken ? 2'd3 : 2'd1;
        end else begin
            hist_next = {decode_info.lht_true[`HIST_BITS-2:0], taken};
            if (!decode_info.pht_valid) begin
                pht_next = 2'd3;
            end else if (taken) begin
                pht_next = (decode_info.pht == 2'd3) ? 2'd3 : decode_info.pht + 2'd1;
            end else begin
                pht_next = (decode_info.pht == 2'd0) ? 2'd0 : decode_info.pht - 2'd1;
            end
        end
    end

    assign upd.ht_web   = ~start;
    assign upd.lht_addr = decode_info.pc[`LHT_IDX_BITS+1:2];
    assign upd.lht_in   = hist_next;
    assign upd.pht_addr = decode_info.lht_valid ? decode_info.lht_true : '0;
    assign upd.pht_in   = pht_next;

    // Only taken branches earn a BTB entry.
    assign upd.btb_web  = ~taken;
    assign upd.btb_addr = decode_info.pc[`BTB_IDX_BITS+1:2];
    assign upd.btb_din  = target;

endmodule : fu_br

// File: rtl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic [31:0] instr,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_v,
    input  logic [31:0] rs2_v,
    output logic [31:0] rd_v,
    output logic        valid,
    output logic        busy,
    output logic        pred_taken,
    output logic [31:0] pred_target,
    output logic        pc_select,
    output logic [31:0] pc_branch
);
    import rv32i_types::*;
    import bp_types::*;

    pred_if      lookup_if ();
    bp_update_if upd_if ();

    logic         lht_valid;
    history_t     lht_true;
    logic         pht_valid;
    counter_t     pht;
    decode_info_t decode_info;

    btb i_btb (
        .clk    (clk),
        .rst    (rst),
        .pc     (pc),
        .lookup (lookup_if.table_side),
        .upd    (upd_if.tables)
    );

    history_tables i_history_tables (
        .clk    (clk),
        .rst    (rst),
        .pc     (pc),
        .lookup (lookup_if.table_side),
        .upd    (upd_if.tables)
    );

    branch_predict i_branch_predict (
        .lookup    (lookup_if.combine_side),
        .bp        (pred_taken),
        .bp_addr   (pred_target),
        .lht_valid (lht_valid),
        .lht_true  (lht_true),
        .pht_valid (pht_valid),
        .pht       (pht)
    );

    branch_decoder i_branch_decoder (
        .instr       (instr),
        .pc          (pc),
        .bp          (pred_taken),
        .bp_addr     (pred_target),
        .lht_valid   (lht_valid),
        .lht_true    (lht_true),
        .pht_valid   (pht_valid),
        .pht         (pht),
        .decode_info (decode_info)
    );

    fu_br i_fu_br (
        .rs1_v       (rs1_v),
        .rs2_v       (rs2_v),
        .decode_info (decode_info),
        .start       (start),
        .rd_v        (rd_v),
        .valid       (valid),
        .busy        (busy),
        .pc_select   (pc_select),
        .pc_branch   (pc_branch),
        .upd         (upd_if.resolver)
    );

endmodule : branch_unit

// File: testbench/tb_branch_unit.sv
`timescale 1ns/1ps
`include "bp_defs.svh"

module tb_branch_unit;
    import bp_types::*;

    localparam int NUM_TESTS = 400;
    localparam int TBL_N     = 1 << `HIST_BITS;   // BTB, LHT and PHT are all this deep.

    logic        clk, rst, start;
    logic [31:0] instr, pc, rs1_v, rs2_v;
    logic [31:0] rd_v, pred_target, pc_branch;
    logic        valid, busy, pred_taken, pc_select;

    logic [15:0] lfsr_state;
    logic [31:0] slot_instr [8];
    logic        m_btb_valid [TBL_N];
    logic [31:0] m_btb_target [TBL_N];
    logic        m_lht_valid [TBL_N];
    history_t    m_lht [TBL_N];
    logic        m_pht_valid [TBL_N];
    counter_t    m_pht [TBL_N];

    branch_unit i_dut (
        .clk(clk), .rst(rst), .start(start), .instr(instr), .pc(pc),
        .rs1_v(rs1_v), .rs2_v(rs2_v), .rd_v(rd_v), .valid(valid), .busy(busy),
        .pred_taken(pred_taken), .pred_target(pred_target),
        .pc_select(pc_select), .pc_branch(pc_branch)
    );

    always #5 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Mostly conditional branches, with jumps and one non-branch opcode mixed in.
    function automatic logic [31:0] make_instr();
        logic [2:0] kind;
        kind = 3'(rand_bits(3));
        case (kind)
            3'd0:    return {25'(rand_bits(25)), 7'b1101111};
            3'd1:    return {25'(rand_bits(25)), 7'b1100111};
            3'd2:    return {25'(rand_bits(25)), 7'b0110011};
            default: return {25'(rand_bits(25)), 7'b1100011};
        endcase
    endfunction

    function automatic logic [31:0] boundary_value(input logic [1:0] sel);
        case (sel)
            2'd0:    return 32'h0000_0000;
            2'd1:    return 32'h7fff_ffff;
            2'd2:    return 32'h8000_0000;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    function automatic logic model_pred(input logic [31:0] p);
        int li;
        int pi;
        li = int'(p[9:2]);
        pi = m_lht_valid[li] ? int'(m_lht[li]) : 0;
        if (!m_btb_valid[li]) return 1'b0;   // No target, no taken prediction.
        if (m_pht_valid[pi]) return m_pht[pi][1];
        return m_lht_valid[li] & m_lht[li][0];
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    task automatic check_counter(input counter_t got, input counter_t exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    task automatic check_branch(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b,
                                input logic [31:0] p);
        logic [31:0] i_imm, b_imm, j_imm, link, target;
        logic        cond, taken, jump, bp, exp_sel;
        int          li, pi;
        history_t    h_next;
        counter_t    c_next;

        i_imm = {{20{w[31]}}, w[31:20]};
        b_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        j_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        li    = int'(p[9:2]);
        pi    = m_lht_valid[li] ? int'(m_lht[li]) : 0;
        bp    = model_pred(p);
        link  = p + 32'd4;
        case (w[14:12])
            3'b000:  cond = (a == b);
            3'b001:  cond = (a != b);
            3'b100:  cond = ($signed(a) < $signed(b));
            3'b101:  cond = ($signed(a) >= $signed(b));
            3'b110:  cond = (a < b);
            3'b111:  cond = (a >= b);
            default: cond = 1'b0;
        endcase
        jump   = (w[6:0] == 7'b1101111) || (w[6:0] == 7'b1100111);
        taken  = jump || ((w[6:0] == 7'b1100011) && cond);
        target = (w[6:0] == 7'b1101111) ? p + j_imm :
                 (w[6:0] == 7'b1100111) ? (a + i_imm) & ~32'd1 : p + b_imm;

        check_bit(valid, 1'b1, "valid");
        check_bit(busy, 1'b1, "busy");
        check_bit(pred_taken, bp, "pred_taken");
        if (m_btb_valid[li]) check_word(pred_target, m_btb_target[li], "pred_target");
        if (jump) check_word(rd_v, link, "rd_v");
        check_bit(i_dut.decode_info.pht_valid, m_pht_valid[pi], "pht valid");
        if (m_pht_valid[pi]) check_counter(i_dut.decode_info.pht, m_pht[pi], "pht counter");

        // Redirect unless the prediction already follows the actual path.
        exp_sel = (bp && !taken) || (taken && !(bp && m_btb_target[li] == target));
        check_bit(pc_select, exp_sel, "pc_select");
        if (exp_sel) check_word(pc_branch, taken ? target : link, "pc_branch");

        if (!m_lht_valid[li]) begin
            h_next = history_t'(taken);
            c_next = taken ? 2'd3 : 2'd1;
        end else begin
            h_next = {m_lht[li][`HIST_BITS-2:0], taken};
            if (!m_pht_valid[pi]) c_next = 2'd3;
            else if (taken) c_next = (m_pht[pi] == 2'd3) ? 2'd3 : m_pht[pi] + 2'd1;
            else c_next = (m_pht[pi] == 2'd0) ? 2'd0 : m_pht[pi] - 2'd1;
        end
        m_lht[li]       = h_next;
        m_lht_valid[li] = 1'b1;
        m_pht[pi]       = c_next;
        m_pht_valid[pi] = 1'b1;
        if (taken) begin
            m_btb_valid[li]  = 1'b1;
            m_btb_target[li] = target;
        end
    endtask

    initial begin
        #((NUM_TESTS + 20) * 10);
        stop_on_error("Timeout: the test sequence did not finish in the expected time.");
    end

    initial begin
        logic [2:0]  slot;
        logic [31:0] p, a, b;

        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        instr = '0;
        pc = '0;
        rs1_v = '0;
        rs2_v = '0;
        lfsr_state = 16'd17;
        for (int i = 0; i < TBL_N; i++) begin
            m_btb_valid[i] = 1'b0;
            m_lht_valid[i] = 1'b0;
            m_pht_valid[i] = 1'b0;
        end
        for (int i = 0; i < 8; i++) slot_instr[i] = make_instr();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_bit(valid, 1'b0, "valid after reset");
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(pc_select, 1'b0, "pc_select after reset");

        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk);
            slot = 3'(rand_bits(3));
            p = 32'h0000_2000 + {27'd0, slot, 2'b00};   // A few pcs, so entries train.
            if (rand_bits(3) == 0) begin
                start = 1'b0;
                pc = p;
                #1;
                check_bit(valid, 1'b0, "idle valid");
                check_bit(busy, 1'b0, "idle busy");
                check_bit(pc_select, 1'b0, "idle pc_select");
                check_bit(pred_taken, model_pred(p), "idle pred_taken");
            end else begin
                if (rand_bits(2) == 0) slot_instr[slot] = make_instr();
                case (2'(rand_bits(2)))
                    2'd0: begin
                        a = rand_bits(32);
                        b = a;
                    end
                    2'd1: begin
                        a = boundary_value(2'(rand_bits(2)));
                        b = boundary_value(2'(rand_bits(2)));
                    end
                    default: begin
                        a = rand_bits(32);
                        b = rand_bits(32);
                    end
                endcase
                start = 1'b1;
                instr = slot_instr[slot];
                pc = p;
                rs1_v = a;
                rs2_v = b;
                #1;
                check_branch(slot_instr[slot], a, b, p);
            end
        end

        @(negedge clk);
        start = 1'b0;
        $display("All checks passed");
        $finish;
    end

endmodule : tb_branch_unit

// File: tb.f
+incdir+rtl
rtl/bp_types.sv
rtl/rv32i_types.sv
rtl/bp_ifs.sv
rtl/branch_decoder.sv
rtl/btb.sv
rtl/history_tables.sv
rtl/branch_predict.sv
rtl/fu_br.sv
rtl/branch_unit.sv
testbench/tb_branch_unit.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= tb.f
TOP       ?= tb_branch_unit
RTL_TOP   ?= branch_unit
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= All checks passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
